// ==== source/mipi_lane_pkg.sv ====
// Lane distributor shared definitions
`default_nettype none

package mipi_lane_pkg;

  // physical lanes and per-lane storage
  localparam int NUM_LANES = 4;
  localparam int BUF_DEPTH = 4;
  localparam int BUF_PTR_W = $clog2(BUF_DEPTH);
  localparam int BYTE_W    = 8;

  // one payload byte
  typedef logic [BYTE_W-1:0] byte_t;

  // active lane count minus one, 0 selects a single lane
  typedef logic [1:0] lane_sel_t;

  // one bit per lane for write enables, pad, active mask and pop
  typedef logic [NUM_LANES-1:0] lane_mask_t;

  // parallel output, lane i sits in byte i
  typedef logic [NUM_LANES*BYTE_W-1:0] lane_word_t;

  // fill level of a lane buffer, holds 0 to BUF_DEPTH
  typedef logic [2:0] buf_cnt_t;

  // read and write positions inside a lane buffer
  typedef logic [BUF_PTR_W-1:0] buf_ptr_t;

  // distributor position relative to a group
  typedef enum logic {
    DIST_IDLE, // at a group boundary
    DIST_FILL  // part of a group has been dealt
  } dist_state_t;

endpackage

`default_nettype wire

// ==== source/mipi_lane_distributor.sv ====
// Round-robin byte dealer
`default_nettype none

module mipi_lane_distributor
  import mipi_lane_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  byte_t      data_in,
  input  logic       valid_in,
  input  logic       last_in,
  input  lane_sel_t  active_lanes,
  output lane_mask_t wr_en,
  output lane_mask_t pad,
  output byte_t      wr_data,
  output logic       wr_last,
  output lane_mask_t active_mask
);

  dist_state_t state;
  lane_sel_t   cfg_sel;      // top lane index of the current group
  lane_mask_t  cfg_mask;
  lane_sel_t   lane_idx;     // lane that takes the next byte of the group
  lane_sel_t   grp_sel;
  lane_mask_t  grp_mask;
  lane_sel_t   grp_lane;
  lane_mask_t  byte_sel;
  lane_mask_t  rest_mask;
  logic        grp_end;
  lane_mask_t  wr_grp_mask;  // group mask travelling with the write
  logic        wr_grp_end;

  function automatic lane_mask_t sel_to_mask(input lane_sel_t sel);
    return lane_mask_t'((5'd2 << sel) - 5'd1);
  endfunction

  // a new group takes the live lane count, a running one keeps its own
  always_comb begin
    if (state == DIST_IDLE) begin
      grp_sel  = active_lanes;
      grp_mask = sel_to_mask(active_lanes);
      grp_lane = '0;
    end else begin
      grp_sel  = cfg_sel;
      grp_mask = cfg_mask;
      grp_lane = lane_idx;
    end
    byte_sel  = lane_mask_t'(1) << grp_lane;
    rest_mask = grp_mask & ~(byte_sel | (byte_sel - lane_mask_t'(1))); // lanes still owed a byte
    grp_end   = last_in || (grp_lane == grp_sel);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= DIST_IDLE;
      cfg_sel     <= '0;
      cfg_mask    <= sel_to_mask('0);
      lane_idx    <= '0;
      wr_en       <= '0;
      pad         <= '0;
      wr_last     <= 1'b0;
      wr_grp_mask <= '0;
      wr_grp_end  <= 1'b0;
      active_mask <= '0;
    end else begin
      // the aligner sees the mask only in the cycle the group is complete
      active_mask <= wr_grp_end ? wr_grp_mask : '0;
      wr_grp_end  <= valid_in && grp_end;
      wr_grp_mask <= grp_mask;
      if (valid_in) begin
        wr_en   <= last_in ? (byte_sel | rest_mask) : byte_sel;
        pad     <= last_in ? rest_mask : '0; // short group is filled with zero bytes
        wr_last <= last_in;
        if (state == DIST_IDLE) begin
          cfg_sel  <= active_lanes;
          cfg_mask <= grp_mask;
        end
        if (grp_end) begin
          state    <= DIST_IDLE;
          lane_idx <= '0;
        end else begin
          state    <= DIST_FILL;
          lane_idx <= grp_lane + lane_sel_t'(1);
        end
      end else begin
        wr_en   <= '0;
        pad     <= '0;
        wr_last <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_in) begin
      wr_data <= data_in;
    end
  end

  a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(valid_in))
    else $error("valid_in is unknown");

endmodule

`default_nettype wire

// ==== source/mipi_lane_buffer.sv ====
// Per-lane byte FIFO
`default_nettype none

module mipi_lane_buffer
  import mipi_lane_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  wr_en,
  input  byte_t wr_data,
  input  logic  pad,
  input  logic  wr_last,
  input  logic  pop,
  output byte_t rd_data,
  output logic  rd_last,
  output logic  not_empty
);

  byte_t    mem [BUF_DEPTH];
  logic     last_mem [BUF_DEPTH];
  buf_ptr_t wr_ptr;
  buf_ptr_t rd_ptr;
  buf_cnt_t cnt;
  logic     full;

  assign full      = (cnt == buf_cnt_t'(BUF_DEPTH));
  assign not_empty = (cnt != '0);
  assign rd_data   = mem[rd_ptr];  // head entry is always on the output
  assign rd_last   = last_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr]      <= pad ? byte_t'(0) : wr_data;
      last_mem[wr_ptr] <= wr_last;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + buf_ptr_t'(1); // depth is a power of two so it wraps
      end
      if (pop) begin
        rd_ptr <= rd_ptr + buf_ptr_t'(1);
      end
      case ({wr_en, pop})
        2'b10:   cnt <= cnt + buf_cnt_t'(1);
        2'b01:   cnt <= cnt - buf_cnt_t'(1);
        default: cnt <= cnt;
      endcase
    end
  end

  // with no back-pressure an overflow would silently drop a byte
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> !full)
    else $error("lane buffer written while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> not_empty)
    else $error("lane buffer popped while empty");

endmodule

`default_nettype wire

// ==== source/mipi_lane_aligner.sv ====
// Lane word aligner
`default_nettype none

module mipi_lane_aligner
  import mipi_lane_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  lane_mask_t active_mask,
  input  lane_word_t rd_data,
  input  lane_mask_t rd_last,
  input  lane_mask_t not_empty,
  output lane_mask_t pop,
  output lane_word_t lane_data,
  output logic       lane_valid,
  output logic       lane_last
);

  logic       all_ready;
  lane_word_t masked;
  logic       last_any;

  always_comb begin
    // an empty mask means no group is complete this cycle
    all_ready = (active_mask != '0) && ((not_empty & active_mask) == active_mask);
    pop       = all_ready ? active_mask : '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      masked[i*BYTE_W +: BYTE_W] = active_mask[i] ? rd_data[i*BYTE_W +: BYTE_W] : byte_t'(0);
    end
    last_any = |(rd_last & active_mask); // padded lanes carry the flag too
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_data  <= '0;
      lane_valid <= 1'b0;
      lane_last  <= 1'b0;
    end else begin
      lane_valid <= all_ready;
      lane_last  <= all_ready && last_any;
      if (all_ready) begin
        lane_data <= masked; // holds the last word between pulses
      end
    end
  end

  a_pop_in_mask: assert property (@(posedge clk) disable iff (!rst_n)
    (pop & ~active_mask) == '0)
    else $error("pop on an inactive lane");

  // the distributor only presents a mask once every byte of the group is stored
  a_group_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (active_mask != '0) |-> (pop == active_mask))
    else $error("group presented before all active lanes were filled");

endmodule

`default_nettype wire

// ==== source/mipi_lane_mux_top.sv ====
// Byte to lane distributor top
`default_nettype none

module mipi_lane_mux_top
  import mipi_lane_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  byte_t      data_in,
  input  logic       valid_in,
  input  logic       last_in,
  input  lane_sel_t  active_lanes,
  output lane_word_t lane_data,
  output logic       lane_valid,
  output logic       lane_last
);

  lane_mask_t wr_en;
  lane_mask_t pad;
  byte_t      wr_data;
  logic       wr_last;
  lane_mask_t active_mask;
  lane_mask_t pop;
  lane_word_t rd_data;
  lane_mask_t rd_last;
  lane_mask_t not_empty;

  mipi_lane_distributor u_dist (
    .clk          (clk),
    .rst_n        (rst_n),
    .data_in      (data_in),
    .valid_in     (valid_in),
    .last_in      (last_in),
    .active_lanes (active_lanes),
    .wr_en        (wr_en),
    .pad          (pad),
    .wr_data      (wr_data),
    .wr_last      (wr_last),
    .active_mask  (active_mask)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    mipi_lane_buffer u_buf (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_en     (wr_en[i]),
      .wr_data   (wr_data),
      .pad       (pad[i]),
      .wr_last   (wr_last),
      .pop       (pop[i]),
      .rd_data   (rd_data[i*BYTE_W +: BYTE_W]),
      .rd_last   (rd_last[i]),
      .not_empty (not_empty[i])
    );
  end

  mipi_lane_aligner u_align (
    .clk         (clk),
    .rst_n       (rst_n),
    .active_mask (active_mask),
    .rd_data     (rd_data),
    .rd_last     (rd_last),
    .not_empty   (not_empty),
    .pop         (pop),
    .lane_data   (lane_data),
    .lane_valid  (lane_valid),
    .lane_last   (lane_last)
  );

endmodule

`default_nettype wire

// ==== verif/mipi_lane_checker.sv ====
// Lane distributor output checker
`default_nettype none

module mipi_lane_checker
  import mipi_lane_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  byte_t      data_in,
  input  logic       valid_in,
  input  logic       last_in,
  input  lane_sel_t  active_lanes,
  input  lane_word_t lane_data,
  input  logic       lane_valid,
  input  logic       lane_last
);

  string       test_name;
  int unsigned groups_checked;
  int unsigned err_cnt;
  lane_word_t  exp_data_q [$];
  logic        exp_last_q [$];
  logic        in_group;     // part of a group has been seen
  lane_sel_t   grp_sel;      // lane count latched for the open group
  lane_sel_t   grp_lane;
  lane_word_t  grp_word;

  initial begin
    test_name      = "none";
    groups_checked = 0;
    err_cnt        = 0;
  end

  task automatic start_test(input string name);
    test_name = name;
  endtask

  function automatic int pending();
    return exp_data_q.size();
  endfunction

  always @(posedge clk or negedge rst_n) begin : model
    lane_sel_t  sel;
    lane_sel_t  lane;
    lane_word_t word;
    lane_word_t exp_word;
    logic       exp_last;
    if (!rst_n) begin
      in_group = 1'b0;  // a partial group is lost on reset
      grp_sel  = '0;
      grp_lane = '0;
      grp_word = '0;
      exp_data_q.delete();
      exp_last_q.delete();
    end else begin
      if ($isunknown(lane_valid)) begin
        $display("lane_valid is unknown during test %s", test_name);
        err_cnt++;
      end else if (lane_valid) begin
        if (exp_data_q.size() == 0) begin
          $display("unexpected lane_valid with data %h in test %s, no group was complete",
                   lane_data, test_name);
          err_cnt++;
        end else begin
          exp_word = exp_data_q.pop_front();
          exp_last = exp_last_q.pop_front();
          groups_checked++;
          if (lane_data !== exp_word) begin
            $display("FAILED %s lane_data expected %h actual %h", test_name, exp_word, lane_data);
            err_cnt++;
          end
          if (lane_last !== exp_last) begin
            $display("FAILED %s lane_last expected %b actual %b", test_name, exp_last, lane_last);
            err_cnt++;
          end
        end
      end
      if (valid_in === 1'b1) begin
        // the lane count is taken only on the first byte of a group
        sel  = in_group ? grp_sel : active_lanes;
        lane = in_group ? grp_lane : lane_sel_t'(0);
        word = in_group ? grp_word : lane_word_t'(0);
        word[lane*BYTE_W +: BYTE_W] = data_in;
        if (last_in || (lane == sel)) begin
          exp_data_q.push_back(word);  // lanes not yet filled stay zero
          exp_last_q.push_back(last_in);
          in_group = 1'b0;
          grp_word = '0;
        end else begin
          in_group = 1'b1;
          grp_sel  = sel;
          grp_lane = lane + lane_sel_t'(1);
          grp_word = word;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/mipi_lane_tb.sv ====
// Lane distributor testbench
`default_nettype none

module mipi_lane_tb
  import mipi_lane_pkg::*;
();

  localparam int PAT_DEPTH   = 128;
  localparam int NUM_TESTS   = 6;
  localparam int DRAIN_LIMIT = 50;

  logic        clk;
  logic        rst_n;
  byte_t       data_in;
  logic        valid_in;
  logic        last_in;
  lane_sel_t   active_lanes;
  lane_word_t  lane_data;
  logic        lane_valid;
  logic        lane_last;
  logic [19:0] pat_mem [PAT_DEPTH];  // control, last, lane count, byte
  string       test_names [NUM_TESTS];
  logic [7:0]  lfsr_state;
  int          tb_errs;
  int          pat_idx;

  mipi_lane_mux_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .data_in      (data_in),
    .valid_in     (valid_in),
    .last_in      (last_in),
    .active_lanes (active_lanes),
    .lane_data    (lane_data),
    .lane_valid   (lane_valid),
    .lane_last    (lane_last)
  );

  mipi_lane_checker chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .data_in      (data_in),
    .valid_in     (valid_in),
    .last_in      (last_in),
    .active_lanes (active_lanes),
    .lane_data    (lane_data),
    .lane_valid   (lane_valid),
    .lane_last    (lane_last)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 8'hb8;  // taps for x^8 + x^6 + x^5 + x^4 + 1
    end
    return s >> 1;
  endfunction

  task automatic apply_reset();
    valid_in = 1'b0;
    last_in  = 1'b0;
    rst_n    = 1'b0;
    repeat (4) begin
      @(posedge clk);
      #1;
    end
    rst_n = 1'b1;
  endtask

  // entered one time unit after a rising edge and leaves at the same point
  task automatic send_byte(input logic [19:0] w, input bit gaps);
    int gap;
    gap = 0;
    if (gaps) begin
      for (int b = 0; b < 2; b++) begin
        gap        = (gap << 1) | lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
      end
    end
    repeat (gap) begin
      valid_in = 1'b0;
      last_in  = 1'b0;
      @(posedge clk);
      #1;
    end
    valid_in     = 1'b1;
    last_in      = w[12];
    active_lanes = w[9:8];
    data_in      = w[7:0];
    @(posedge clk);
    #1;
  endtask

  task automatic wait_drain(input string name);
    int cycles;
    cycles = 0;
    while ((chk.pending() != 0) && (cycles < DRAIN_LIMIT)) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (chk.pending() != 0) begin
      $display("%s timed out, %0d expected groups never appeared on lane_valid",
               name, chk.pending());
      tb_errs++;
    end
    repeat (4) begin  // window that catches stray lane_valid pulses
      @(posedge clk);
      #1;
    end
  endtask

  initial begin : main
    int          t;
    int          errs_before;
    int          groups_before;
    int          test_errs;
    int          total_errs;
    logic [19:0] w;
    bit          done;
    test_names[0] = "four_lane_burst";
    test_names[1] = "one_two_lanes";
    test_names[2] = "lane_change_mid_group";
    test_names[3] = "last_pads_short_group";
    test_names[4] = "random_gaps";
    test_names[5] = "reset_clears_state";
    lfsr_state   = 8'd45;
    tb_errs      = 0;
    pat_idx      = 0;
    data_in      = '0;
    valid_in     = 1'b0;
    last_in      = 1'b0;
    active_lanes = '0;
    rst_n        = 1'b0;
    $readmemh("verif/mipi_lane_patterns.hex", pat_mem);
    apply_reset();
    for (t = 0; t < NUM_TESTS; t++) begin
      errs_before   = chk.err_cnt + tb_errs;
      groups_before = chk.groups_checked;
      chk.start_test(test_names[t]);
      done = 1'b0;
      while (!done && (pat_idx < PAT_DEPTH)) begin
        w = pat_mem[pat_idx];
        pat_idx++;
        case (w[19:16])
          4'h0:    send_byte(w, t != 0);  // the first test runs back to back
          4'h2:    apply_reset();
          default: done = 1'b1;
        endcase
      end
      valid_in = 1'b0;
      last_in  = 1'b0;
      if (!done) begin
        $display("pattern file ran out during test %s", test_names[t]);
        tb_errs++;
      end
      wait_drain(test_names[t]);
      test_errs = chk.err_cnt + tb_errs - errs_before;
      if (test_errs == 0) begin
        $display("%s passed, %0d groups", test_names[t], chk.groups_checked - groups_before);
      end else begin
        $display("%s failed with %0d errors", test_names[t], test_errs);
      end
    end
    total_errs = chk.err_cnt + tb_errs;
    $display("tests %0d, groups checked %0d, errors %0d",
             NUM_TESTS, chk.groups_checked, total_errs);
    if (total_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/mipi_lane_patterns.hex ====
// columns C L A DD: control (0 byte, 1 end of test, 2 reset), last flag,
// active_lanes (0 is one lane, 3 is four), data byte
// four lanes back to back
00311 00312 00313 00314
00315 00316 00317 00318
10000
// one lane, then two lanes
00021
00022
00123 00124
00125 00126
10000
// four lanes latched, count changes inside the group
00331 00032 00133 00334
00035
00136 00237
10000
// last on short and on complete groups
00341 01342
00243 00244 01245
01146
01047
10000
// random idle gaps
00351 00352 00353 00354
00355 00356 00357 00358
00159 0015a
0115b
10000
// partial group dropped by reset, then single lanes
00361 00362
20000
00063
00064
01065
10000

// ==== project.f ====
source/mipi_lane_pkg.sv
source/mipi_lane_distributor.sv
source/mipi_lane_buffer.sv
source/mipi_lane_aligner.sv
source/mipi_lane_mux_top.sv
verif/mipi_lane_checker.sv
verif/mipi_lane_tb.sv
